//--- cpu_pkg.sv
package cpu_pkg;

    // default data width for word_t
    localparam int WORD_SIZE = 16;
    localparam int NUM_REGS = 8;

    typedef logic [WORD_SIZE-1:0] word_t;
    typedef logic [2:0] reg_idx_t;
    typedef logic [2:0] opcode_t;

    // opcode field, bits 15:13 of the instruction
    localparam opcode_t OP_MV = 3'd0;
    localparam opcode_t OP_MVT_B = 3'd1;     // imm=1 is mvt, imm=0 is b
    localparam opcode_t OP_ADD = 3'd2;
    localparam opcode_t OP_SUB = 3'd3;
    localparam opcode_t OP_LD = 3'd4;
    localparam opcode_t OP_ST = 3'd5;
    localparam opcode_t OP_CMP = 3'd7;       // 6 decodes as a nop

    localparam reg_idx_t REG_PC = 3'd7;

    // alu_none in a valid decode entry marks a branch
    typedef enum logic [2:0] {
        alu_none,
        alu_mov,
        alu_movt,
        alu_add,
        alu_sub
    } alu_op_t;

    // taken from the rX field of a branch
    typedef enum logic [2:0] {
        cond_none = 3'd0,
        cond_eq,
        cond_ne,
        cond_cc,
        cond_cs,
        cond_pl,
        cond_mi
    } cond_t;

endpackage

//--- decode_unit.sv
module decode_unit #(
    parameter int WORD_SIZE = 16
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic                 fetch_valid,
    input  logic [WORD_SIZE-1:0] fetch_instr,
    input  logic [WORD_SIZE-1:0] fetch_pc,
    input  logic [WORD_SIZE-1:0] data_a,
    input  logic [WORD_SIZE-1:0] data_b,
    output cpu_pkg::reg_idx_t    read_a,
    output cpu_pkg::reg_idx_t    read_b,
    input  logic                 ex_valid,
    input  logic                 ex_writeback,
    input  cpu_pkg::reg_idx_t    ex_rx,
    input  logic                 mem_valid,
    input  logic                 mem_writeback,
    input  cpu_pkg::reg_idx_t    mem_rx,
    input  logic                 hold,
    input  logic                 flush,
    output logic                 hazard,
    output logic                 dec_valid,
    output cpu_pkg::reg_idx_t    dec_rx,
    output logic [WORD_SIZE-1:0] dec_op1,
    output logic [WORD_SIZE-1:0] dec_op2,
    output cpu_pkg::alu_op_t     dec_alu_op,
    output cpu_pkg::cond_t       dec_cond,
    output logic                 dec_read,
    output logic                 dec_write,
    output logic                 dec_writeback,
    output logic                 dec_update_flags,
    output logic [WORD_SIZE-1:0] dec_pc
);

    cpu_pkg::opcode_t opcode;
    cpu_pkg::reg_idx_t rx;
    cpu_pkg::reg_idx_t ry;
    cpu_pkg::alu_op_t alu_op;
    cpu_pkg::cond_t cond;
    logic imm;
    logic [WORD_SIZE-1:0] imm_sext;
    logic [WORD_SIZE-1:0] imm_high;
    logic [WORD_SIZE-1:0] op2;
    logic valid, read, write, writeback, update_flags;
    logic use_rx, use_ry;
    logic [cpu_pkg::NUM_REGS-1:0] busy;     // destinations still in flight

    // III M XXX DDDDDDDDD or III M XXX 000000 YYY
    assign opcode = fetch_instr[15:13];
    assign imm = fetch_instr[12];
    assign rx = fetch_instr[11:9];
    assign ry = fetch_instr[2:0];
    assign imm_sext = {{(WORD_SIZE-9){fetch_instr[8]}}, fetch_instr[8:0]};
    assign imm_high = {fetch_instr[7:0], {(WORD_SIZE-8){1'b0}}};  // mvt clears the low byte

    assign read_a = rx;
    assign read_b = ry;

    always_comb begin
        valid = fetch_valid && (fetch_instr != '0);  // all-zero word is a nop
        alu_op = cpu_pkg::alu_none;
        cond = cpu_pkg::cond_none;
        op2 = imm ? imm_sext : data_b;
        read = 1'b0;
        write = 1'b0;
        writeback = 1'b0;
        update_flags = 1'b0;
        use_rx = 1'b0;
        use_ry = !imm;
        case (opcode)
            cpu_pkg::OP_MV: begin
                alu_op = cpu_pkg::alu_mov;
                writeback = 1'b1;
            end
            cpu_pkg::OP_MVT_B: begin
                use_ry = 1'b0;
                if (imm) begin
                    alu_op = cpu_pkg::alu_movt;
                    op2 = imm_high;
                    writeback = 1'b1;
                end else begin
                    cond = cpu_pkg::cond_t'(rx);
                    op2 = imm_sext;         // branch offset with alu_op left at alu_none
                end
            end
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: begin
                alu_op = (opcode == cpu_pkg::OP_ADD) ? cpu_pkg::alu_add : cpu_pkg::alu_sub;
                writeback = 1'b1;
                update_flags = 1'b1;
                use_rx = 1'b1;
            end
            cpu_pkg::OP_LD, cpu_pkg::OP_ST: begin
                alu_op = cpu_pkg::alu_mov;  // address rides through as the result
                op2 = data_b;
                read = (opcode == cpu_pkg::OP_LD);
                write = (opcode == cpu_pkg::OP_ST);
                writeback = (opcode == cpu_pkg::OP_LD);
                use_rx = 1'b1;
                use_ry = 1'b1;
            end
            cpu_pkg::OP_CMP: begin
                alu_op = cpu_pkg::alu_sub;
                update_flags = 1'b1;
                use_rx = 1'b1;
            end
            default: valid = 1'b0;
        endcase
    end

    always_comb begin
        busy = '0;
        if (dec_valid && dec_writeback) busy[dec_rx] = 1'b1;
        if (ex_valid && ex_writeback) busy[ex_rx] = 1'b1;
        if (mem_valid && mem_writeback) busy[mem_rx] = 1'b1;
    end

    assign hazard = valid && ((use_rx && busy[rx]) || (use_ry && busy[ry]));

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            dec_valid <= 1'b0;
            dec_read <= 1'b0;
            dec_write <= 1'b0;
            dec_writeback <= 1'b0;
            dec_update_flags <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0;
        end else if (!hold) begin
            dec_valid <= valid && !hazard;  // bubble into execute on a hazard
            dec_read <= read;
            dec_write <= write;
            dec_writeback <= writeback;
            dec_update_flags <= update_flags;
        end
    end

    always_ff @(posedge Clock) begin
        if (!hold) begin
            dec_rx <= rx;
            dec_op1 <= data_a;
            dec_op2 <= op2;
            dec_alu_op <= alu_op;
            dec_cond <= cond;
            dec_pc <= fetch_pc;
        end
    end

endmodule

//--- execute_unit.sv
module execute_unit #(
    parameter int WORD_SIZE = 16
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic                 dec_valid,
    input  cpu_pkg::reg_idx_t    dec_rx,
    input  logic [WORD_SIZE-1:0] dec_op1,
    input  logic [WORD_SIZE-1:0] dec_op2,
    input  cpu_pkg::alu_op_t     dec_alu_op,
    input  cpu_pkg::cond_t       dec_cond,
    input  logic                 dec_read,
    input  logic                 dec_write,
    input  logic                 dec_writeback,
    input  logic                 dec_update_flags,
    input  logic [WORD_SIZE-1:0] dec_pc,
    input  logic                 stall,
    output logic                 branch_taken,
    output logic [WORD_SIZE-1:0] branch_target,
    output logic                 ex_valid,
    output cpu_pkg::reg_idx_t    ex_rx,
    output logic [WORD_SIZE-1:0] ex_op1,
    output logic [WORD_SIZE-1:0] ex_result,
    output logic                 ex_read,
    output logic                 ex_write,
    output logic                 ex_writeback
);

    logic [WORD_SIZE-1:0] result;
    logic carry, overflow;
    logic is_branch, cond_met;
    logic [3:0] flags;      // n z c v

    always_comb begin
        result = dec_op2;   // mov, movt and the ld/st address
        carry = 1'b0;
        overflow = 1'b0;
        case (dec_alu_op)
            cpu_pkg::alu_add: begin
                {carry, result} = {1'b0, dec_op1} + {1'b0, dec_op2};
                overflow = (dec_op1[WORD_SIZE-1] == dec_op2[WORD_SIZE-1]) &&
                           (result[WORD_SIZE-1] != dec_op1[WORD_SIZE-1]);
            end
            cpu_pkg::alu_sub: begin
                result = dec_op1 - dec_op2;
                carry = (dec_op1 >= dec_op2);   // no borrow
                overflow = (dec_op1[WORD_SIZE-1] != dec_op2[WORD_SIZE-1]) &&
                           (result[WORD_SIZE-1] != dec_op1[WORD_SIZE-1]);
            end
            default: ;
        endcase
    end

    always_comb begin
        case (dec_cond)
            cpu_pkg::cond_eq: cond_met = flags[2];
            cpu_pkg::cond_ne: cond_met = !flags[2];
            cpu_pkg::cond_cc: cond_met = !flags[1];
            cpu_pkg::cond_cs: cond_met = flags[1];
            cpu_pkg::cond_pl: cond_met = !flags[3];
            cpu_pkg::cond_mi: cond_met = flags[3];
            default: cond_met = 1'b1;
        endcase
    end

    assign is_branch = dec_valid && (dec_alu_op == cpu_pkg::alu_none);
    assign branch_taken = is_branch && cond_met && !stall;
    assign branch_target = dec_pc + dec_op2 + WORD_SIZE'(1);  // offset -1 loops on itself

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            flags <= '0;
            ex_valid <= 1'b0;
            ex_read <= 1'b0;
            ex_write <= 1'b0;
            ex_writeback <= 1'b0;
        end else if (!stall) begin
            if (dec_valid && dec_update_flags)
                flags <= {result[WORD_SIZE-1], result == '0, carry, overflow};
            ex_valid <= dec_valid && !is_branch;    // resolved branches leave as bubbles
            ex_read <= dec_read;
            ex_write <= dec_write;
            ex_writeback <= dec_writeback;
        end
    end

    always_ff @(posedge Clock) begin
        if (!stall) begin
            ex_rx <= dec_rx;
            ex_op1 <= dec_op1;
            ex_result <= result;
        end
    end

endmodule

//--- fetch_unit.sv
module fetch_unit #(
    parameter int WORD_SIZE = 16
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic [WORD_SIZE-1:0] InstrIn,
    input  logic                 hold,
    input  logic                 branch_taken,
    input  logic [WORD_SIZE-1:0] branch_target,
    output logic [WORD_SIZE-1:0] InstrAddr,
    output logic                 fetch_valid,
    output logic [WORD_SIZE-1:0] fetch_instr,
    output logic [WORD_SIZE-1:0] fetch_pc
);

    logic [WORD_SIZE-1:0] pc;

    assign InstrAddr = pc;  // instruction memory answers combinationally

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc <= '0;
            fetch_valid <= 1'b0;
        end else if (branch_taken) begin
            // redirect wins over a hazard hold
            pc <= branch_target;
            fetch_valid <= 1'b0;
        end else if (!hold) begin
            pc <= pc + WORD_SIZE'(1);
            fetch_valid <= 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (!hold && !branch_taken) begin
            fetch_instr <= InstrIn;
            fetch_pc <= pc;     // address of the captured word
        end
    end

endmodule

//--- memory_unit.sv
module memory_unit #(
    parameter int WORD_SIZE = 16
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic                 ex_valid,
    input  cpu_pkg::reg_idx_t    ex_rx,
    input  logic [WORD_SIZE-1:0] ex_op1,
    input  logic [WORD_SIZE-1:0] ex_result,
    input  logic                 ex_read,
    input  logic                 ex_write,
    input  logic                 ex_writeback,
    input  logic [WORD_SIZE-1:0] DataIn,
    input  logic                 DataDone,
    output logic [WORD_SIZE-1:0] DataAddr,
    output logic [WORD_SIZE-1:0] DataOut,
    output logic                 ReadData,
    output logic                 WriteData,
    output logic                 mem_wait,
    output logic                 write_en,
    output cpu_pkg::reg_idx_t    write_idx,
    output logic [WORD_SIZE-1:0] write_data,
    output logic                 mem_valid,
    output logic                 mem_writeback,
    output cpu_pkg::reg_idx_t    mem_rx
);

    logic request;
    logic [WORD_SIZE-1:0] mem_result;

    // the execute register is the request, held while DataDone stays low
    assign request = ex_valid && (ex_read || ex_write);
    assign ReadData = ex_valid && ex_read;
    assign WriteData = ex_valid && ex_write;
    assign DataAddr = ex_result;    // value of rY
    assign DataOut = ex_op1;        // value of rX for st
    assign mem_wait = request && !DataDone;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            mem_valid <= 1'b0;
            mem_writeback <= 1'b0;
        end else begin
            mem_valid <= ex_valid && !mem_wait;     // bubble while waiting
            mem_writeback <= ex_writeback;
        end
    end

    always_ff @(posedge Clock) begin
        mem_rx <= ex_rx;
        mem_result <= ex_read ? DataIn : ex_result;
    end

    // register write happens as the instruction leaves this stage
    assign write_en = mem_valid && mem_writeback;
    assign write_idx = mem_rx;
    assign write_data = mem_result;

endmodule

//--- processor.sv
module processor #(
    parameter int WORD_SIZE = 16
) (
    input  logic           Clock,
    input  logic           Reset,
    input  cpu_pkg::word_t InstrIn,
    input  cpu_pkg::word_t DataIn,
    input  logic           DataDone,
    output cpu_pkg::word_t InstrAddr,
    output cpu_pkg::word_t DataAddr,
    output cpu_pkg::word_t DataOut,
    output logic           ReadData,
    output logic           WriteData
);

    logic hazard;
    logic mem_wait;
    logic hold_front;
    logic branch_taken;
    logic [WORD_SIZE-1:0] branch_target;

    logic fetch_valid;
    logic [WORD_SIZE-1:0] fetch_instr;
    logic [WORD_SIZE-1:0] fetch_pc;

    cpu_pkg::reg_idx_t read_a;
    cpu_pkg::reg_idx_t read_b;
    logic [WORD_SIZE-1:0] data_a;
    logic [WORD_SIZE-1:0] data_b;

    logic dec_valid;
    cpu_pkg::reg_idx_t dec_rx;
    logic [WORD_SIZE-1:0] dec_op1;
    logic [WORD_SIZE-1:0] dec_op2;
    cpu_pkg::alu_op_t dec_alu_op;
    cpu_pkg::cond_t dec_cond;
    logic dec_read;
    logic dec_write;
    logic dec_writeback;
    logic dec_update_flags;
    logic [WORD_SIZE-1:0] dec_pc;

    logic ex_valid;
    cpu_pkg::reg_idx_t ex_rx;
    logic [WORD_SIZE-1:0] ex_op1;
    logic [WORD_SIZE-1:0] ex_result;
    logic ex_read;
    logic ex_write;
    logic ex_writeback;

    logic mem_valid;
    logic mem_writeback;
    cpu_pkg::reg_idx_t mem_rx;
    logic write_en;
    cpu_pkg::reg_idx_t write_idx;
    logic [WORD_SIZE-1:0] write_data;

    assign hold_front = hazard || mem_wait;     // fetch stops for either

    fetch_unit #(.WORD_SIZE(WORD_SIZE)) i_fetch_unit (
        .Clock, .Reset, .InstrIn, .hold(hold_front), .branch_taken, .branch_target,
        .InstrAddr, .fetch_valid, .fetch_instr, .fetch_pc
    );

    // r7 reads as the address of the instruction being decoded
    register_file #(.WORD_SIZE(WORD_SIZE)) i_register_file (
        .Clock, .Reset, .read_a, .read_b, .data_a, .data_b,
        .write_en, .write_idx, .write_data, .pc_value(fetch_pc)
    );

    decode_unit #(.WORD_SIZE(WORD_SIZE)) i_decode_unit (
        .Clock, .Reset, .fetch_valid, .fetch_instr, .fetch_pc, .data_a, .data_b,
        .read_a, .read_b, .ex_valid, .ex_writeback, .ex_rx,
        .mem_valid, .mem_writeback, .mem_rx,
        .hold(mem_wait), .flush(branch_taken), .hazard,
        .dec_valid, .dec_rx, .dec_op1, .dec_op2, .dec_alu_op, .dec_cond,
        .dec_read, .dec_write, .dec_writeback, .dec_update_flags, .dec_pc
    );

    execute_unit #(.WORD_SIZE(WORD_SIZE)) i_execute_unit (
        .Clock, .Reset, .dec_valid, .dec_rx, .dec_op1, .dec_op2, .dec_alu_op,
        .dec_cond, .dec_read, .dec_write, .dec_writeback, .dec_update_flags, .dec_pc,
        .stall(mem_wait), .branch_taken, .branch_target,
        .ex_valid, .ex_rx, .ex_op1, .ex_result, .ex_read, .ex_write, .ex_writeback
    );

    memory_unit #(.WORD_SIZE(WORD_SIZE)) i_memory_unit (
        .Clock, .Reset, .ex_valid, .ex_rx, .ex_op1, .ex_result, .ex_read, .ex_write,
        .ex_writeback, .DataIn, .DataDone, .DataAddr, .DataOut, .ReadData, .WriteData,
        .mem_wait, .write_en, .write_idx, .write_data,
        .mem_valid, .mem_writeback, .mem_rx
    );

endmodule

//--- register_file.sv
module register_file #(
    parameter int WORD_SIZE = 16
) (
    input  logic              Clock,
    input  logic              Reset,
    input  cpu_pkg::reg_idx_t read_a,
    input  cpu_pkg::reg_idx_t read_b,
    output cpu_pkg::word_t    data_a,
    output cpu_pkg::word_t    data_b,
    input  logic              write_en,
    input  cpu_pkg::reg_idx_t write_idx,
    input  cpu_pkg::word_t    write_data,
    input  cpu_pkg::word_t    pc_value
);

    // r7 is the program counter in fetch_unit so only r0..r6 live here
    logic [WORD_SIZE-1:0] regs [cpu_pkg::NUM_REGS-1];

    assign data_a = (read_a == cpu_pkg::REG_PC) ? pc_value : regs[read_a];
    assign data_b = (read_b == cpu_pkg::REG_PC) ? pc_value : regs[read_b];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS - 1; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_idx != cpu_pkg::REG_PC) begin
            regs[write_idx] <= write_data;  // writes to r7 are dropped
        end
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps --top-module tb_processor \
    -f verilog.f -o sim_processor &&
./obj_dir/sim_processor ||
exit 1

//--- tb_processor.sv
module tb_processor;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLE_LIMIT = 3000;  // all three programs together need well under 1000

    logic Clock;
    logic Reset;
    logic [15:0] InstrIn;
    logic [15:0] DataIn;
    logic DataDone;
    logic [15:0] InstrAddr;
    logic [15:0] DataAddr;
    logic [15:0] DataOut;
    logic ReadData;
    logic WriteData;

    logic [15:0] imem [256];
    logic [15:0] dmem [65536];
    logic [7:0] load_ptr;
    logic [15:0] lfsr_state;
    logic [15:0] log_addr [$];
    logic [15:0] log_data [$];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    int read_count;
    int wait_left;
    int cycle_count;
    bit access_open;

    processor #(.WORD_SIZE(16)) i_processor (
        .Clock, .Reset, .InstrIn, .DataIn, .DataDone,
        .InstrAddr, .DataAddr, .DataOut, .ReadData, .WriteData
    );

    assign InstrIn = imem[InstrAddr[7:0]];  // combinational instruction port

    always #4 Clock = ~Clock;

    function automatic logic [15:0] enc(logic [2:0] op, logic imm, logic [2:0] rx,
                                        logic [8:0] low);
        return {op, imm, rx, low};  // low holds the immediate or ry in bits 2:0
    endfunction

    function automatic logic [15:0] fill_value(logic [15:0] addr);
        return (addr * 16'd40503) ^ 16'h3C5A;
    endfunction

    // galois lfsr stepped once per random bit
    function automatic logic lfsr_step();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 16'hB400;
        return out;
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string name, logic [15:0] got, logic [15:0] want);
        assert (got === want) else begin
            $display("error at %0d ns: %s is %h, expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    // data memory answers 0 to 3 cycles after the request shows up
    always @(negedge Clock) begin
        DataDone = 1'b0;
        if (Reset) begin
            access_open = 1'b0;
        end else if (ReadData || WriteData) begin
            if (!access_open) begin
                access_open = 1'b1;
                wait_left = int'(lfsr_step());
                wait_left = 2 * wait_left + int'(lfsr_step());
            end
            if (wait_left == 0) begin
                DataDone = 1'b1;
                access_open = 1'b0;     // the access ends at the coming rising edge
                if (ReadData) begin
                    DataIn = dmem[DataAddr];
                    read_count++;
                end else begin
                    dmem[DataAddr] = DataOut;
                    log_addr.push_back(DataAddr);
                    log_data.push_back(DataOut);
                end
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge Clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("cycle limit of %0d reached before the programs finished", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic enter_reset();
        @(negedge Clock);
        Reset = 1'b1;
        load_ptr = 8'd0;
        log_addr.delete();
        log_data.delete();
        exp_addr.delete();
        exp_data.delete();
        read_count = 0;
        for (int i = 0; i < 256; i++) begin
            imem[8'(i)] = 16'd0;
        end
    endtask

    task automatic leave_reset();
        repeat (2) @(posedge Clock);
        @(negedge Clock);
        Reset = 1'b0;
        check_value("InstrAddr", InstrAddr, 16'd0);
        check_value("ReadData", {15'd0, ReadData}, 16'd0);
        check_value("WriteData", {15'd0, WriteData}, 16'd0);
    endtask

    task automatic emit(logic [15:0] word);
        imem[load_ptr] = word;
        load_ptr = load_ptr + 8'd1;
    endtask

    task automatic expect_write(logic [15:0] addr, logic [15:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // wait for the expected stores, then watch the idle self-loop for 20 cycles
    task automatic compare_write_log(int exp_reads);
        while (log_data.size() < exp_data.size()) begin
            @(negedge Clock);
        end
        repeat (20) begin
            @(negedge Clock);
            check_value("ReadData", {15'd0, ReadData}, 16'd0);
            check_value("WriteData", {15'd0, WriteData}, 16'd0);
        end
        assert (log_data.size() == exp_data.size()) else begin
            $display("more data writes happened than the program contains");
            abort_run();
        end
        check_value("load count", 16'(read_count), 16'(exp_reads));
        foreach (exp_data[i]) begin
            check_value("DataAddr", log_addr[i], exp_addr[i]);
            check_value("DataOut", log_data[i], exp_data[i]);
        end
    endtask

    task automatic arithmetic_stores();
        logic [15:0] r1, r2, r3, r4;
        enter_reset();
        emit(enc(cpu_pkg::OP_MV, 1'b1, 3'd6, 9'd32));
        emit(enc(cpu_pkg::OP_MV, 1'b1, 3'd1, 9'd100));
        emit(enc(cpu_pkg::OP_MV, 1'b1, 3'd2, 9'h1F9));      // -7
        emit(enc(cpu_pkg::OP_ADD, 1'b0, 3'd1, 9'd2));
        emit(enc(cpu_pkg::OP_MVT_B, 1'b1, 3'd3, 9'h0A5));
        emit(enc(cpu_pkg::OP_ADD, 1'b1, 3'd3, 9'h0FF));
        emit(enc(cpu_pkg::OP_SUB, 1'b0, 3'd3, 9'd1));
        emit(enc(cpu_pkg::OP_SUB, 1'b1, 3'd2, 9'd200));
        emit(enc(cpu_pkg::OP_MV, 1'b0, 3'd4, 9'd3));
        emit(enc(cpu_pkg::OP_ADD, 1'b0, 3'd4, 9'd4));       // carries out of bit 15
        for (int i = 1; i <= 4; i++) begin
            emit(enc(cpu_pkg::OP_ST, 1'b0, 3'(i), 9'd6));
            emit(enc(cpu_pkg::OP_ADD, 1'b1, 3'd6, 9'd1));
        end
        emit(enc(cpu_pkg::OP_MVT_B, 1'b0, 3'd0, 9'h1FF));
        r1 = 16'd100;
        r2 = 16'hFFF9;
        r1 = r1 + r2;
        r3 = 16'hA500 + 16'd255;
        r3 = r3 - r1;
        r2 = r2 - 16'd200;
        r4 = r3 + r3;
        expect_write(16'd32, r1);
        expect_write(16'd33, r2);
        expect_write(16'd34, r3);
        expect_write(16'd35, r4);
        leave_reset();
        compare_write_log(0);
    endtask

    task automatic load_store_chain();
        logic [15:0] a, b, s;
        enter_reset();
        emit(enc(cpu_pkg::OP_MV, 1'b1, 3'd5, 9'd100));
        emit(enc(cpu_pkg::OP_LD, 1'b0, 3'd1, 9'd5));
        emit(enc(cpu_pkg::OP_ADD, 1'b1, 3'd5, 9'd1));
        emit(enc(cpu_pkg::OP_LD, 1'b0, 3'd2, 9'd5));
        emit(enc(cpu_pkg::OP_ADD, 1'b0, 3'd1, 9'd2));
        emit(enc(cpu_pkg::OP_SUB, 1'b0, 3'd2, 9'd1));
        emit(enc(cpu_pkg::OP_MV, 1'b1, 3'd6, 9'h1CE));      // -50
        emit(enc(cpu_pkg::OP_ST, 1'b0, 3'd1, 9'd6));
        emit(enc(cpu_pkg::OP_LD, 1'b0, 3'd3, 9'd6));        // read back the store
        emit(enc(cpu_pkg::OP_ADD, 1'b1, 3'd3, 9'd1));
        emit(enc(cpu_pkg::OP_ADD, 1'b1, 3'd6, 9'd1));
        emit(enc(cpu_pkg::OP_ST, 1'b0, 3'd2, 9'd6));
        emit(enc(cpu_pkg::OP_ST, 1'b0, 3'd3, 9'd5));
        emit(enc(cpu_pkg::OP_LD, 1'b0, 3'd4, 9'd5));
        emit(enc(cpu_pkg::OP_ADD, 1'b1, 3'd6, 9'd1));
        emit(enc(cpu_pkg::OP_ST, 1'b0, 3'd4, 9'd6));
        emit(enc(cpu_pkg::OP_MVT_B, 1'b0, 3'd0, 9'h1FF));
        a = fill_value(16'd100);
        b = fill_value(16'd101);
        s = a + b;
        expect_write(16'hFFCE, s);
        expect_write(16'hFFCF, b - s);
        expect_write(16'd101, s + 16'd1);
        expect_write(16'hFFD0, s + 16'd1);
        leave_reset();
        compare_write_log(4);
    endtask

    task automatic branch_conditions();
        logic [15:0] operands [4];
        logic [15:0] diff;
        logic [6:0] met;    // bit order follows the cond encoding
        int marker;
        operands = '{16'd5, 16'd9, 16'd2, 16'hFFFD};
        marker = 0;
        enter_reset();
        emit(enc(cpu_pkg::OP_MV, 1'b1, 3'd2, 9'd5));
        emit(enc(cpu_pkg::OP_MV, 1'b1, 3'd6, 9'd64));
        for (int c = 0; c < 7; c++) begin
            foreach (operands[k]) begin
                diff = 16'd5 - operands[k];
                met = {diff[15], !diff[15], 16'd5 >= operands[k], 16'd5 < operands[k],
                       diff != 16'd0, diff == 16'd0, 1'b1};
                emit(enc(cpu_pkg::OP_CMP, 1'b1, 3'd2, operands[k][8:0]));
                emit(enc(cpu_pkg::OP_MVT_B, 1'b0, 3'(c), 9'd2));    // skips the next two
                emit(enc(cpu_pkg::OP_MV, 1'b1, 3'd1, 9'(marker)));
                emit(enc(cpu_pkg::OP_ST, 1'b0, 3'd1, 9'd6));
                emit(enc(cpu_pkg::OP_MV, 1'b1, 3'd1, 9'(marker + 1)));
                emit(enc(cpu_pkg::OP_ST, 1'b0, 3'd1, 9'd6));
                if (!met[3'(c)]) begin
                    expect_write(16'd64, 16'(marker));
                end
                expect_write(16'd64, 16'(marker + 1));
                marker += 2;
            end
        end
        emit(enc(cpu_pkg::OP_MVT_B, 1'b0, 3'd0, 9'h1FF));
        leave_reset();
        compare_write_log(0);
    endtask

    initial begin
        Clock = 1'b0;
        Reset = 1'b1;
        DataIn = 16'd0;
        DataDone = 1'b0;
        access_open = 1'b0;
        wait_left = 0;
        cycle_count = 0;
        read_count = 0;
        load_ptr = 8'd0;
        lfsr_state = 16'd11933;
        for (int i = 0; i < 256; i++) begin
            imem[8'(i)] = 16'd0;
        end
        for (int i = 0; i < 65536; i++) begin
            dmem[16'(i)] = fill_value(16'(i));
        end
        arithmetic_stores();
        load_store_chain();
        branch_conditions();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- verilog.f
cpu_pkg.sv
fetch_unit.sv
register_file.sv
decode_unit.sv
execute_unit.sv
memory_unit.sv
processor.sv
tb_processor.sv
